// File: rtl/exu_defs.svh
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

`define EXU_XLEN            32
`define EXU_NREGS           32

// immediate formats, expanded in execute.
`define EXU_IMM_12I         2'd0
`define EXU_IMM_20U         2'd1
`define EXU_IMM_20J         2'd2
`define EXU_IMM_12B         2'd3

`define EXU_SRC1_REG        2'd0
`define EXU_SRC1_PC         2'd1
`define EXU_SRC1_ZERO       2'd2

`define EXU_SRC2_IMM        2'd0
`define EXU_SRC2_REG        2'd1
`define EXU_SRC2_FOUR       2'd2

`define EXU_ALU_ADD         4'd0
`define EXU_ALU_SUB         4'd1
`define EXU_ALU_SLL         4'd2
`define EXU_ALU_SLT         4'd3
`define EXU_ALU_SLTU        4'd4
`define EXU_ALU_XOR         4'd5
`define EXU_ALU_SRL         4'd6
`define EXU_ALU_SRA         4'd7
`define EXU_ALU_OR          4'd8
`define EXU_ALU_AND         4'd9
`define EXU_ALU_PASS2       4'd10
// equality compare for beq, bne takes it with the invert flag.
`define EXU_ALU_EQ          4'd11

`endif

// File: rtl/exu_pkg.sv
`include "exu_defs.svh"

package exu_pkg;

    // one data word or pc.
    typedef logic [`EXU_XLEN-1:0] word_t;

    typedef logic [$clog2(`EXU_NREGS)-1:0] reg_addr_t;

    typedef logic [3:0] alu_op_t;

    typedef logic [1:0] imm_fmt_t;

    // shared by the operand-1 and operand-2 selects.
    typedef logic [1:0] src_sel_t;

endpackage

// File: rtl/exu_regfile.sv
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  exu_pkg::reg_addr_t rd_addr1,
    input  exu_pkg::reg_addr_t rd_addr2,
    output exu_pkg::word_t     rd_data1,
    output exu_pkg::word_t     rd_data2,
    input  logic               wr_en,
    input  exu_pkg::reg_addr_t wr_addr,
    input  exu_pkg::word_t     wr_data
);

    exu_pkg::word_t regs [`EXU_NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `EXU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // no bypass, hazards stall until the write has landed.
    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

    a_x0_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rd_addr1 == '0) |-> (rd_data1 == '0)
    );

endmodule

// File: rtl/exu_alu.sv
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_alu (
    input  exu_pkg::word_t   d1,
    input  exu_pkg::word_t   d2,
    input  exu_pkg::alu_op_t op,
    output exu_pkg::word_t   res
);

    logic [4:0] shamt;

    assign shamt = d2[4:0];

    always_comb begin
        case (op)
            `EXU_ALU_ADD:   res = d1 + d2;
            `EXU_ALU_SUB:   res = d1 - d2;
            `EXU_ALU_SLL:   res = d1 << shamt;
            `EXU_ALU_SLT:   res = exu_pkg::word_t'($signed(d1) < $signed(d2));
            `EXU_ALU_SLTU:  res = exu_pkg::word_t'(d1 < d2);
            `EXU_ALU_XOR:   res = d1 ^ d2;
            `EXU_ALU_SRL:   res = d1 >> shamt;
            `EXU_ALU_SRA:   res = exu_pkg::word_t'($signed(d1) >>> shamt);
            `EXU_ALU_OR:    res = d1 | d2;
            `EXU_ALU_AND:   res = d1 & d2;
            `EXU_ALU_PASS2: res = d2;
            `EXU_ALU_EQ:    res = exu_pkg::word_t'(d1 == d2);
            default:        res = '0;
        endcase
    end

endmodule

// File: rtl/exu_operand_read.sv
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_operand_read (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               issue_valid,
    input  exu_pkg::word_t     issue_pc,
    input  exu_pkg::reg_addr_t issue_rs1,
    input  exu_pkg::reg_addr_t issue_rs2,
    input  exu_pkg::reg_addr_t issue_rd,
    input  logic               issue_rd_wen,
    input  exu_pkg::word_t     issue_imm,
    input  exu_pkg::imm_fmt_t  issue_imm_fmt,
    input  exu_pkg::alu_op_t   issue_alu_op,
    input  logic               issue_inv,
    input  logic               issue_jump,
    input  logic               issue_branch,
    input  exu_pkg::src_sel_t  issue_src1_sel,
    input  exu_pkg::src_sel_t  issue_src2_sel,
    output logic               issue_ready,
    output exu_pkg::reg_addr_t rf_addr1,
    output exu_pkg::reg_addr_t rf_addr2,
    input  exu_pkg::word_t     rf_data1,
    input  exu_pkg::word_t     rf_data2,
    input  logic               ex_valid,
    input  exu_pkg::reg_addr_t ex_rd,
    input  logic               ex_rd_wen,
    input  logic               ready_next,
    output logic               valid_next,
    output exu_pkg::word_t     pc,
    output exu_pkg::reg_addr_t rd,
    output logic               rd_wen,
    output exu_pkg::word_t     imm,
    output exu_pkg::imm_fmt_t  imm_fmt,
    output exu_pkg::alu_op_t   alu_op,
    output logic               inv,
    output logic               jump,
    output logic               branch,
    output exu_pkg::src_sel_t  src1_sel,
    output exu_pkg::src_sel_t  src2_sel,
    output exu_pkg::word_t     rs1_value,
    output exu_pkg::word_t     rs2_value
);

    logic src1_used;
    logic src2_used;
    logic hazard1;
    logic hazard2;
    logic hazard;
    logic issue_fire;

    assign rf_addr1 = issue_rs1;
    assign rf_addr2 = issue_rs2;

    // branches compare both registers.
    assign src1_used = issue_branch || (issue_src1_sel == `EXU_SRC1_REG);
    assign src2_used = issue_branch || (issue_src2_sel == `EXU_SRC2_REG);

    // pending writers sit here or in execute.
    assign hazard1 = src1_used && (issue_rs1 != '0) &&
                     ((valid_next && rd_wen && (rd == issue_rs1)) ||
                      (ex_valid && ex_rd_wen && (ex_rd == issue_rs1)));
    assign hazard2 = src2_used && (issue_rs2 != '0) &&
                     ((valid_next && rd_wen && (rd == issue_rs2)) ||
                      (ex_valid && ex_rd_wen && (ex_rd == issue_rs2)));
    assign hazard  = hazard1 || hazard2;

    assign issue_ready = ready_next && !hazard;
    assign issue_fire  = issue_valid && issue_ready;

    // an issue taken while flush is high is dropped as a younger op.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_next <= 1'b0;
        end else if (flush) begin
            valid_next <= 1'b0;
        end else if (ready_next) begin
            valid_next <= issue_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            pc        <= issue_pc;
            rd        <= issue_rd;
            rd_wen    <= issue_rd_wen;
            imm       <= issue_imm;
            imm_fmt   <= issue_imm_fmt;
            alu_op    <= issue_alu_op;
            inv       <= issue_inv;
            jump      <= issue_jump;
            branch    <= issue_branch;
            src1_sel  <= issue_src1_sel;
            src2_sel  <= issue_src2_sel;
            rs1_value <= rf_data1;
            rs2_value <= rf_data2;
        end
    end

    // the producer has left execute two edges into a stall.
    a_stall_bounded: assert property (
        @(posedge clk) disable iff (!rst_n)
        (issue_valid && hazard && $past(issue_valid && hazard)) |=> !hazard
    );

endmodule

// File: rtl/exu_execute.sv
`timescale 1ns/1ps
`include "exu_defs.svh"

module exu_execute (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               inst_clear,
    input  logic               valid_last,
    input  exu_pkg::word_t     pc,
    input  exu_pkg::reg_addr_t rd,
    input  logic               rd_wen,
    input  exu_pkg::word_t     imm,
    input  exu_pkg::imm_fmt_t  imm_fmt,
    input  exu_pkg::alu_op_t   alu_op,
    input  logic               inv,
    input  logic               jump,
    input  logic               branch,
    input  exu_pkg::src_sel_t  src1_sel,
    input  exu_pkg::src_sel_t  src2_sel,
    input  exu_pkg::word_t     rs1_value,
    input  exu_pkg::word_t     rs2_value,
    input  logic               ready_next,
    output logic               ready_last,
    output logic               valid_next,
    output exu_pkg::word_t     pc_next,
    output exu_pkg::reg_addr_t rd_next,
    output logic               rd_wen_next,
    output logic               jump_next,
    output logic               branch_next,
    output exu_pkg::word_t     imm_next,
    output exu_pkg::word_t     ex_result
);

    exu_pkg::word_t     pc_q;
    exu_pkg::reg_addr_t rd_q;
    exu_pkg::word_t     imm_q;
    exu_pkg::imm_fmt_t  imm_fmt_q;
    exu_pkg::alu_op_t   alu_op_q;
    logic               inv_q;
    exu_pkg::src_sel_t  src1_sel_q;
    exu_pkg::src_sel_t  src2_sel_q;
    exu_pkg::word_t     rs1_q;
    exu_pkg::word_t     rs2_q;
    logic               rd_wen_q;
    logic               jump_q;
    logic               branch_q;
    logic               take;
    exu_pkg::word_t     imm_ext;
    exu_pkg::word_t     op1;
    exu_pkg::word_t     op2;
    exu_pkg::word_t     alu_res;

    assign ready_last = ready_next;
    assign take       = valid_last && ready_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_next <= 1'b0;
        end else if (ready_last) begin
            valid_next <= valid_last && !inst_clear;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pc_q       <= pc;
            rd_q       <= rd;
            imm_q      <= imm;
            imm_fmt_q  <= imm_fmt;
            alu_op_q   <= alu_op;
            inv_q      <= inv;
            src1_sel_q <= src1_sel;
            src2_sel_q <= src2_sel;
            rs1_q      <= rs1_value;
            rs2_q      <= rs2_value;
        end
    end

    // killed op keeps its payload but loses every side effect.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_wen_q <= 1'b0;
            jump_q   <= 1'b0;
            branch_q <= 1'b0;
        end else if (inst_clear && valid_last && ready_last) begin
            rd_wen_q <= 1'b0;
            jump_q   <= 1'b0;
            branch_q <= 1'b0;
        end else if (take) begin
            rd_wen_q <= rd_wen;
            jump_q   <= jump;
            branch_q <= branch;
        end
    end

    always_comb begin
        case (imm_fmt_q)
            `EXU_IMM_12I: imm_ext = {{20{imm_q[11]}}, imm_q[11:0]};
            `EXU_IMM_20U: imm_ext = {imm_q[19:0], 12'd0};
            `EXU_IMM_20J: imm_ext = {{11{imm_q[19]}}, imm_q[19:0], 1'b0};
            `EXU_IMM_12B: imm_ext = {{19{imm_q[11]}}, imm_q[11:0], 1'b0};
            default:      imm_ext = '0;
        endcase
    end

    always_comb begin
        case (src1_sel_q)
            `EXU_SRC1_REG: op1 = rs1_q;
            `EXU_SRC1_PC:  op1 = pc_q;
            default:       op1 = '0;
        endcase
    end

    always_comb begin
        case (src2_sel_q)
            `EXU_SRC2_IMM:  op2 = imm_ext;
            `EXU_SRC2_REG:  op2 = rs2_q;
            `EXU_SRC2_FOUR: op2 = 32'd4;
            default:        op2 = '0;
        endcase
    end

    exu_alu u_alu (
        .d1  (op1),
        .d2  (op2),
        .op  (alu_op_q),
        .res (alu_res)
    );

    // invert only touches the compare bit.
    assign ex_result   = alu_res ^ {{(`EXU_XLEN-1){1'b0}}, inv_q};
    assign pc_next     = pc_q;
    assign rd_next     = rd_q;
    assign rd_wen_next = rd_wen_q;
    assign jump_next   = jump_q;
    assign branch_next = branch_q;
    assign imm_next    = imm_ext;

    a_imm_fmt_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_last |-> (!$isunknown(imm_fmt) && (imm_fmt inside {`EXU_IMM_12I,
            `EXU_IMM_20U, `EXU_IMM_20J, `EXU_IMM_12B}))
    );

endmodule

// File: rtl/exu_writeback.sv
`timescale 1ns/1ps

module exu_writeback (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               valid_last,
    input  exu_pkg::word_t     pc,
    input  exu_pkg::reg_addr_t rd,
    input  logic               rd_wen,
    input  logic               jump,
    input  logic               branch,
    input  exu_pkg::word_t     imm,
    input  exu_pkg::word_t     ex_result,
    output logic               ready_last,
    output logic               flush,
    output logic               rf_wen,
    output exu_pkg::reg_addr_t rf_waddr,
    output exu_pkg::word_t     rf_wdata,
    output logic               wb_valid,
    output exu_pkg::reg_addr_t wb_rd,
    output exu_pkg::word_t     wb_data,
    output logic               redirect_valid,
    output exu_pkg::word_t     redirect_pc
);

    logic           taken;
    exu_pkg::word_t target;

    // last stage, never back-pressures.
    assign ready_last = 1'b1;

    assign taken  = jump || (branch && ex_result[0]);
    assign flush  = valid_last && taken;
    assign target = pc + imm;

    assign rf_wen   = valid_last && rd_wen && (rd != '0);
    assign rf_waddr = rd;
    assign rf_wdata = ex_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid       <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            wb_valid       <= valid_last;
            redirect_valid <= flush;
        end
    end

    // branches report rd 0 and the compare result.
    always_ff @(posedge clk) begin
        if (valid_last) begin
            wb_rd       <= rd_wen ? rd : '0;
            wb_data     <= ex_result;
            redirect_pc <= target;
        end
    end

    // the op right behind a redirect is killed in execute.
    a_redirect_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect_valid |=> !redirect_valid
    );

endmodule

// File: rtl/exu_top.sv
`timescale 1ns/1ps

module exu_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue_valid,
    input  exu_pkg::word_t     issue_pc,
    input  exu_pkg::reg_addr_t issue_rs1,
    input  exu_pkg::reg_addr_t issue_rs2,
    input  exu_pkg::reg_addr_t issue_rd,
    input  logic               issue_rd_wen,
    input  exu_pkg::word_t     issue_imm,
    input  exu_pkg::imm_fmt_t  issue_imm_fmt,
    input  exu_pkg::alu_op_t   issue_alu_op,
    input  logic               issue_inv,
    input  logic               issue_jump,
    input  logic               issue_branch,
    input  exu_pkg::src_sel_t  issue_src1_sel,
    input  exu_pkg::src_sel_t  issue_src2_sel,
    output logic               issue_ready,
    output logic               wb_valid,
    output exu_pkg::reg_addr_t wb_rd,
    output exu_pkg::word_t     wb_data,
    output logic               redirect_valid,
    output exu_pkg::word_t     redirect_pc
);

    exu_pkg::reg_addr_t rf_addr1;
    exu_pkg::reg_addr_t rf_addr2;
    exu_pkg::word_t     rf_data1;
    exu_pkg::word_t     rf_data2;
    logic               rf_wen;
    exu_pkg::reg_addr_t rf_waddr;
    exu_pkg::word_t     rf_wdata;
    logic               flush;

    // operation held in operand read, names match both stages.
    logic               rd_valid;
    logic               rd_ready;
    exu_pkg::word_t     pc;
    exu_pkg::reg_addr_t rd;
    logic               rd_wen;
    exu_pkg::word_t     imm;
    exu_pkg::imm_fmt_t  imm_fmt;
    exu_pkg::alu_op_t   alu_op;
    logic               inv;
    logic               jump;
    logic               branch;
    exu_pkg::src_sel_t  src1_sel;
    exu_pkg::src_sel_t  src2_sel;
    exu_pkg::word_t     rs1_value;
    exu_pkg::word_t     rs2_value;

    logic               ex_valid;
    exu_pkg::word_t     ex_pc;
    exu_pkg::reg_addr_t ex_rd;
    logic               ex_rd_wen;
    logic               ex_jump;
    logic               ex_branch;
    exu_pkg::word_t     ex_imm;
    exu_pkg::word_t     ex_result;
    logic               wb_ready;

    exu_regfile u_regfile (
        .clk, .rst_n,
        .rd_addr1 (rf_addr1), .rd_addr2 (rf_addr2),
        .rd_data1 (rf_data1), .rd_data2 (rf_data2),
        .wr_en    (rf_wen),   .wr_addr  (rf_waddr), .wr_data (rf_wdata)
    );

    exu_operand_read u_operand_read (
        .ready_next (rd_ready),
        .valid_next (rd_valid),
        .*
    );

    exu_execute u_execute (
        .inst_clear  (flush),
        .valid_last  (rd_valid),
        .ready_last  (rd_ready),
        .ready_next  (wb_ready),
        .valid_next  (ex_valid),
        .pc_next     (ex_pc),
        .rd_next     (ex_rd),
        .rd_wen_next (ex_rd_wen),
        .jump_next   (ex_jump),
        .branch_next (ex_branch),
        .imm_next    (ex_imm),
        .*
    );

    exu_writeback u_writeback (
        .clk, .rst_n,
        .valid_last (ex_valid),  .pc     (ex_pc),     .rd  (ex_rd),
        .rd_wen     (ex_rd_wen), .jump   (ex_jump),   .branch (ex_branch),
        .imm        (ex_imm),    .ex_result,
        .ready_last (wb_ready),  .flush,
        .rf_wen, .rf_waddr, .rf_wdata,
        .wb_valid, .wb_rd, .wb_data,
        .redirect_valid, .redirect_pc
    );

endmodule

// File: testbench/tb_exu.sv
`timescale 1ns/1ps
`include "exu_defs.svh"

module tb_exu;

    localparam int MAX_WORDS  = 1024;
    localparam int CLK_PERIOD = 4;

    logic               clk;
    logic               rst_n;
    logic               issue_valid;
    exu_pkg::word_t     issue_pc;
    exu_pkg::reg_addr_t issue_rs1;
    exu_pkg::reg_addr_t issue_rs2;
    exu_pkg::reg_addr_t issue_rd;
    logic               issue_rd_wen;
    exu_pkg::word_t     issue_imm;
    exu_pkg::imm_fmt_t  issue_imm_fmt;
    exu_pkg::alu_op_t   issue_alu_op;
    logic               issue_inv;
    logic               issue_jump;
    logic               issue_branch;
    exu_pkg::src_sel_t  issue_src1_sel;
    exu_pkg::src_sel_t  issue_src2_sel;
    logic               issue_ready;
    logic               wb_valid;
    exu_pkg::reg_addr_t wb_rd;
    exu_pkg::word_t     wb_data;
    logic               redirect_valid;
    exu_pkg::word_t     redirect_pc;

    logic [`EXU_XLEN-1:0] stim [MAX_WORDS];
    // expected commits, oldest first.
    logic [127:0]         exp_q [$];
    int                   errors;
    int                   checks;
    int                   num_records;
    int                   stall_cycles;
    bit                   loaded;

    exu_top dut (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic string test_name(input logic [7:0] id);
        case (id)
            8'h01:   return "alu";
            8'h02:   return "chain";
            8'h03:   return "branch";
            8'h04:   return "jal";
            8'h05:   return "flush";
            8'h06:   return "reset";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h", test, what, expected, actual);
        end
    endtask

    task automatic issue_op(input logic [31:0] ctrl, input logic [31:0] regs,
                            input logic [31:0] pc, input logic [31:0] imm);
        @(negedge clk);
        issue_valid    = 1'b1;
        issue_alu_op   = ctrl[27:24];
        issue_imm_fmt  = ctrl[21:20];
        issue_src1_sel = ctrl[17:16];
        issue_src2_sel = ctrl[13:12];
        issue_inv      = ctrl[11];
        issue_jump     = ctrl[10];
        issue_branch   = ctrl[9];
        issue_rd_wen   = ctrl[8];
        issue_rs1      = regs[28:24];
        issue_rs2      = regs[20:16];
        issue_rd       = regs[12:8];
        issue_pc       = pc;
        issue_imm      = imm;
        #1;
        // ready settles well before the next rising edge.
        while (!issue_ready) begin
            if (ctrl[7:0] == 8'h02) begin
                stall_cycles++;
            end
            @(negedge clk);
            #1;
        end
        @(posedge clk);
    endtask

    task automatic hold_issue_idle(input int cycles);
        @(negedge clk);
        issue_valid = 1'b0;
        repeat (cycles) @(posedge clk);
    endtask

    // each commit pops one expected record.
    always @(negedge clk) begin
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] w3;
        string       name;
        if (rst_n && wb_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected commit with rd %0d and data %h", wb_rd, wb_data);
            end else begin
                {w0, w1, w2, w3} = exp_q.pop_front();
                name = test_name(w0[7:0]);
                check_value(name, "wb_rd", w1, 32'(wb_rd));
                check_value(name, "wb_data", w2, wb_data);
                check_value(name, "redirect_valid", 32'(w0[8]), 32'(redirect_valid));
                if (w0[8]) begin
                    check_value(name, "redirect_pc", w3, redirect_pc);
                end
            end
        end
    end

    initial begin
        wait (loaded);
        #((num_records * 40 + 200) * CLK_PERIOD);
        $display("timeout after %0d cycles with the pipeline still busy",
                 num_records * 40 + 200);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int          idx;
        int          drain;
        logic [31:0] w0;
        errors         = 0;
        checks         = 0;
        stall_cycles   = 0;
        loaded         = 1'b0;
        rst_n          = 1'b0;
        issue_valid    = 1'b0;
        issue_pc       = '0;
        issue_rs1      = '0;
        issue_rs2      = '0;
        issue_rd       = '0;
        issue_rd_wen   = 1'b0;
        issue_imm      = '0;
        issue_imm_fmt  = `EXU_IMM_12I;
        issue_alu_op   = `EXU_ALU_ADD;
        issue_inv      = 1'b0;
        issue_jump     = 1'b0;
        issue_branch   = 1'b0;
        issue_src1_sel = `EXU_SRC1_REG;
        issue_src2_sel = `EXU_SRC2_IMM;
        $readmemh("testbench/exu_input.mem", stim);
        for (idx = 0; idx < MAX_WORDS; idx += 4) begin
            if (stim[idx][31:28] === 4'hF) begin
                break;
            end
        end
        if (idx >= MAX_WORDS) begin
            errors++;
            $display("stimulus file is missing or has no end record");
        end else begin
            num_records = idx / 4 + 1;
            loaded      = 1'b1;
            repeat (16) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            #1;
            check_value("reset", "wb_valid", 32'd0, 32'(wb_valid));
            check_value("reset", "redirect_valid", 32'd0, 32'(redirect_valid));
            check_value("reset", "issue_ready", 32'd1, 32'(issue_ready));
            for (idx = 0; idx < num_records * 4; idx += 4) begin
                w0 = stim[idx];
                case (w0[31:28])
                    4'h1: issue_op(w0, stim[idx + 1], stim[idx + 2], stim[idx + 3]);
                    4'h2: begin
                        exp_q.push_back({w0, stim[idx + 1], stim[idx + 2], stim[idx + 3]});
                        if (w0[15:12] != 4'd0) begin
                            hold_issue_idle(int'(w0[15:12]));
                        end
                    end
                    4'hF: hold_issue_idle(1);
                    default: begin
                        errors++;
                        $display("unknown record kind %h at word %0d", w0[31:28], idx);
                    end
                endcase
            end
            drain = 0;
            while (exp_q.size() != 0 && drain < 32) begin
                @(negedge clk);
                drain++;
            end
            repeat (4) @(negedge clk);
            if (exp_q.size() != 0) begin
                errors++;
                $display("%0d expected commits never arrived", exp_q.size());
            end
            if (stall_cycles == 0) begin
                errors++;
                $display("issue_ready never dropped during the dependent chain");
            end
        end
        $display("checks: %0d, stall cycles: %0d, errors: %0d", checks, stall_cycles, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+rtl
rtl/exu_pkg.sv
rtl/exu_regfile.sv
rtl/exu_alu.sv
rtl/exu_operand_read.sv
rtl/exu_execute.sv
rtl/exu_writeback.sv
rtl/exu_top.sv
testbench/tb_exu.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ps -Wall
TOP       ?= tb_exu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "run reported failure"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || (echo "run ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/exu_input.mem
// op: 1,alu,fmt,src1,src2,flags(inv jump branch rd_wen),test | rs1 rs2 rd 00 | pc | imm
// expect: 2,000,gap,redirect,test | wb_rd | wb_data | redirect_pc; F0000000 ends the run
10000101 00000100 00000100 00000123 20000001 00000001 00000123 00000000
10000101 00000200 00000104 00000FFB 20000001 00000002 FFFFFFFB 00000000
1A120101 00000300 00000108 00012345 20000001 00000003 12345000 00000000
10110101 00000400 0000010C 00000001 20000001 00000004 0000110C 00000000
10001101 01020500 00000110 00000000 20000001 00000005 0000011E 00000000
11001101 01020600 00000114 00000000 20000001 00000006 00000128 00000000
15001101 03010700 00000118 00000000 20000001 00000007 12345123 00000000
18001101 03020800 0000011C 00000000 20000001 00000008 FFFFFFFB 00000000
12000101 01000A00 00000120 00000004 20000001 0000000A 00001230 00000000
17000101 02000B00 00000124 00000001 20000001 0000000B FFFFFFFD 00000000
13001101 02010D00 00000128 00000000 20000001 0000000D 00000001 00000000
14001101 02010E00 0000012C 00000000 20000001 0000000E 00000000 00000000
10000101 01000000 00000130 00000001 20000001 00000000 00000124 00000000
10001102 00010F00 00000140 00000000 20000002 0000000F 00000123 00000000
10000102 0F001200 00000144 00000010 20000002 00000012 00000133 00000000
11001102 120F1300 00000148 00000000 20000002 00000013 00000010 00000000
1B301203 01020000 00000200 00000010 20000003 00000000 00000000 00000000
1B301203 01010000 00000204 00000010 20004103 00000000 00000001 00000224
1B301A03 01010000 00000208 00000008 20000003 00000000 00000000 00000000
1B301A03 01020000 0000020C 00000FF8 20004103 00000000 00000001 000001FC
13301203 01020000 00000210 00000040 20000003 00000000 00000000 00000000
13301203 02010000 00000214 00000040 20004103 00000000 00000001 00000294
13301A03 02010000 00000218 000007FF 20000003 00000000 00000000 00000000
13301A03 01020000 0000021C 000007FF 20004103 00000000 00000001 0000121A
10212504 00001000 00000300 000FFFF0 20004104 00000010 00000304 000002E0
1B301205 01010000 00000400 00000008 20000105 00000000 00000001 00000410
10000105 00001400 00000404 00000055
10000105 00001500 00000408 00000066
10001105 10011100 0000040C 00000000 20000005 00000011 00000427 00000000
10001105 14151600 00000410 00000000 20000005 00000016 00000000 00000000
F0000000 00000000 00000000 00000000
